//--- source/wfd_daq_pkg.sv
// wfd daq path definitions

package wfd_daq_pkg;

    // channel link side, one word per transfer
    typedef logic [31:0] chan_word_t;

    // amc13 event data word, two channel words wide
    typedef logic [63:0] daq_word_t;

    // event number in header and trailer, wraps after 2^24 events
    typedef logic [23:0] event_num_t;

    // words per event, header and trailer included
    typedef logic [19:0] word_count_t;

    // event buffer geometry
    localparam int FIFO_DEPTH  = 16;   // packed words held between producer and consumer
    localparam int FIFO_ADDR_W = 4;    // log2 of the depth

    // marker bytes, top byte of the framing words
    localparam logic [7:0] HDR_MARK = 8'h5a;   // header word
    localparam logic [7:0] TRL_MARK = 8'ha0;   // trailer word

    // header word layout
    //   [63:56] HDR_MARK
    //   [55:32] event number
    //   [31:0]  zero
    //
    // trailer word layout
    //   [63:56] TRL_MARK
    //   [55:32] event number
    //   [31:20] zero
    //   [19:0]  word count, header and trailer included
    //
    // packed data word
    //   [63:32] first channel word of the pair
    //   [31:0]  second channel word, zero for the odd word at the end of an event

endpackage

//--- source/chan_word_packer.sv
// channel word packer

`timescale 1ns/10ps

module chan_word_packer (
    input  logic                    clk125,      // event data clock
    input  logic                    rst_n,
    // channel link side
    input  logic                    chan_valid,
    input  wfd_daq_pkg::chan_word_t chan_data,
    input  logic                    chan_last,   // final word of the event
    output logic                    chan_ready,
    // buffer write side
    input  logic                    full,
    output logic                    wr_en,
    output wfd_daq_pkg::daq_word_t  wr_data,
    output logic                    wr_last      // packed word closes the event
);
    import wfd_daq_pkg::*;

    chan_word_t hi_word;     // first word of a pair, waiting for its partner
    logic       hi_vld;      // upper half occupied
    logic       pend;        // packed word waiting to go into the buffer
    logic       pend_next;
    logic       accept;      // channel word transfers this cycle
    logic       complete;    // accepted word closes a packed word

    assign accept   = chan_valid & chan_ready;
    assign complete = accept & (hi_vld | chan_last);   // second half, or a lone last word

    // the buffer takes the pending word as soon as it has room
    assign wr_en = pend & ~full;

    // pending flag for the next cycle
    always_comb begin
        pend_next = pend;
        if (complete) begin
            pend_next = 1'b1;    // fresh word, the old one left this cycle
        end else if (wr_en) begin
            pend_next = 1'b0;
        end
    end

    // control state
    always_ff @(posedge clk125 or negedge rst_n) begin
        if (!rst_n) begin
            hi_vld     <= 1'b0;
            pend       <= 1'b0;
            chan_ready <= 1'b1;
        end else begin
            pend <= pend_next;
            if (accept) begin
                hi_vld <= ~complete;   // a word that does not complete opens a pair
            end
            // registered inverse of full
            // also drops for one cycle when a write and a new word meet, since the
            // buffer may fill on this edge and the new word then has to wait
            chan_ready <= ~full & ~(wr_en & pend_next);
        end
    end

    // packing registers, the data path itself
    always_ff @(posedge clk125) begin
        if (accept) begin
            if (hi_vld) begin
                wr_data <= {hi_word, chan_data};           // upper then lower
            end else if (chan_last) begin
                wr_data <= {chan_data, chan_word_t'(0)};   // odd word, pad low half
            end else begin
                hi_word <= chan_data;                      // hold until the partner arrives
            end
            if (complete) begin
                wr_last <= chan_last;                      // copied from the completing word
            end
        end
    end

    // pairing runs straight across event boundaries only when chan_last is absent,
    // so every event starts with an empty upper half

endmodule

//--- source/event_fifo.sv
// packed word event buffer

`timescale 1ns/10ps

module event_fifo (
    input  logic                   clk125,
    input  logic                   rst_n,
    // write side, from the packer
    input  logic                   wr_en,
    input  wfd_daq_pkg::daq_word_t wr_data,
    input  logic                   wr_last,
    output logic                   full,
    // read side, first word fall-through
    input  logic                   rd_en,     // pop the head entry
    output wfd_daq_pkg::daq_word_t rd_data,
    output logic                   rd_last,
    output logic                   empty
);
    import wfd_daq_pkg::*;

    daq_word_t              mem_data [FIFO_DEPTH];   // packed words
    logic                   mem_last [FIFO_DEPTH];   // end of event flags
    logic [FIFO_ADDR_W-1:0] wr_ptr;                  // wraps on its own, depth is a power of two
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic [FIFO_ADDR_W:0]   count;                   // occupancy, 0 to FIFO_DEPTH
    logic                   push;
    logic                   pop;

    assign full  = (count == (FIFO_ADDR_W+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign pop  = rd_en & ~empty;
    assign push = wr_en & (~full | pop);   // a full buffer still takes a word on a pop

    // head entry shown without a read cycle
    assign rd_data = mem_data[rd_ptr];
    assign rd_last = mem_last[rd_ptr];

    // storage
    always_ff @(posedge clk125) begin
        if (push) begin
            mem_data[wr_ptr] <= wr_data;
            mem_last[wr_ptr] <= wr_last;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk125 or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither, level unchanged
            endcase
        end
    end

endmodule

//--- source/daq_event_builder.sv
// amc13 event builder

`timescale 1ns/10ps

module daq_event_builder (
    input  logic                   clk125,
    input  logic                   rst_n,
    // buffer read side
    input  logic                   empty,
    input  wfd_daq_pkg::daq_word_t rd_data,
    input  logic                   rd_last,       // head entry closes the event
    output logic                   rd_en,
    // amc13 event data interface
    output logic                   daq_valid,
    output logic                   daq_header,
    output logic                   daq_trailer,
    output wfd_daq_pkg::daq_word_t daq_data,
    input  logic                   daq_ready      // level from the daq link
);
    import wfd_daq_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,      // between events
        ST_HEADER,    // header beat on the bus
        ST_PAYLOAD,   // moving packed words
        ST_TRAILER    // last data word sent, trailer owed
    } state_t;

    state_t      state;
    event_num_t  evt_num;        // event number of the event in progress
    word_count_t word_cnt;       // beats sent so far in this event
    word_count_t word_cnt_inc;
    daq_word_t   hdr_word;
    daq_word_t   trl_word;
    logic        start;          // header beat registered this cycle
    logic        take;           // data beat registered this cycle
    logic        close;          // trailer beat registered this cycle
    logic        in_event;

    assign in_event = (state == ST_HEADER) | (state == ST_PAYLOAD);

    // every beat needs daq_ready seen high on the edge that registers it
    assign start = (state == ST_IDLE) & ~empty & daq_ready;
    assign take  = in_event & ~empty & daq_ready;
    assign close = (state == ST_TRAILER) & daq_ready;

    assign rd_en = take;   // pop on the same edge that captures the word

    assign word_cnt_inc = word_cnt + 1'b1;

    // framing words
    assign hdr_word = {HDR_MARK, evt_num, 32'h0000_0000};
    assign trl_word = {TRL_MARK, evt_num, 12'h000, word_cnt_inc};   // count includes trailer

    // event FSM and beat flags
    always_ff @(posedge clk125 or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            evt_num     <= '0;
            word_cnt    <= '0;
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
        end else begin
            // single cycle beats by default
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        daq_valid  <= 1'b1;
                        daq_header <= 1'b1;
                        word_cnt   <= word_count_t'(1);   // header is beat one
                        state      <= ST_HEADER;
                    end
                end

                ST_HEADER, ST_PAYLOAD: begin
                    if (take) begin
                        daq_valid <= 1'b1;
                        word_cnt  <= word_cnt_inc;
                        // trailer follows the entry that carried the last flag
                        state     <= rd_last ? ST_TRAILER : ST_PAYLOAD;
                    end else begin
                        state     <= ST_PAYLOAD;   // stalled, empty or not ready
                    end
                end

                ST_TRAILER: begin
                    if (close) begin
                        daq_valid   <= 1'b1;
                        daq_trailer <= 1'b1;
                        word_cnt    <= word_cnt_inc;
                        evt_num     <= evt_num + 1'b1;   // wraps at 2^24
                        state       <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // output word register, only meaningful while daq_valid is high
    always_ff @(posedge clk125) begin
        if (start) begin
            daq_data <= hdr_word;
        end else if (take) begin
            daq_data <= rd_data;    // packed word straight from the buffer head
        end else if (close) begin
            daq_data <= trl_word;
        end
    end

endmodule

//--- source/wfd_daq_path.sv
// wfd event data path top

`timescale 1ns/10ps

module wfd_daq_path (
    input  logic                    clk125,       // single clock for the whole path
    input  logic                    rst_n,
    // channel link side
    input  logic                    chan_valid,
    input  wfd_daq_pkg::chan_word_t chan_data,
    input  logic                    chan_last,
    output logic                    chan_ready,
    // amc13 event data side
    output logic                    daq_valid,
    output logic                    daq_header,
    output logic                    daq_trailer,
    output wfd_daq_pkg::daq_word_t  daq_data,
    input  logic                    daq_ready
);
    import wfd_daq_pkg::*;

    // packer to buffer
    logic      wr_en;
    daq_word_t wr_data;
    logic      wr_last;
    logic      full;

    // buffer to builder
    logic      rd_en;
    daq_word_t rd_data;
    logic      rd_last;
    logic      empty;

    // pairs of 32 bit channel words into 64 bit daq words
    chan_word_packer packer (
        .clk125     (clk125),
        .rst_n      (rst_n),
        .chan_valid (chan_valid),
        .chan_data  (chan_data),
        .chan_last  (chan_last),
        .chan_ready (chan_ready),
        .full       (full),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .wr_last    (wr_last)
    );

    // absorbs daq_ready back-pressure
    event_fifo buffer (
        .clk125  (clk125),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .wr_last (wr_last),
        .full    (full),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .rd_last (rd_last),
        .empty   (empty)
    );

    // header, payload, trailer towards the amc13
    daq_event_builder builder (
        .clk125      (clk125),
        .rst_n       (rst_n),
        .empty       (empty),
        .rd_data     (rd_data),
        .rd_last     (rd_last),
        .rd_en       (rd_en),
        .daq_valid   (daq_valid),
        .daq_header  (daq_header),
        .daq_trailer (daq_trailer),
        .daq_data    (daq_data),
        .daq_ready   (daq_ready)
    );

endmodule

//--- tests/wfd_daq_path_sva.sv
// daq output protocol assertions

`timescale 1ns/10ps

module wfd_daq_path_sva (
    input logic clk125,
    input logic rst_n,
    input logic daq_valid,
    input logic daq_header,
    input logic daq_trailer,
    input logic daq_ready,
    input logic chan_ready
);
    int fail_count = 0;   // failed assertions, summed into the run result

    // framing flags only ride on a beat
    a_flag_valid: assert property (@(posedge clk125) disable iff (!rst_n)
        (daq_header || daq_trailer) |-> daq_valid)
        else begin
            fail_count++;
            $error("header or trailer flag without daq_valid");
        end

    a_flag_excl: assert property (@(posedge clk125) disable iff (!rst_n)
        !(daq_header && daq_trailer))
        else begin
            fail_count++;
            $error("header and trailer flags in the same beat");
        end

    // a beat is registered only on an edge that saw daq_ready high
    a_valid_ready: assert property (@(posedge clk125) disable iff (!rst_n)
        daq_valid |-> $past(daq_ready))
        else begin
            fail_count++;
            $error("daq_valid after a cycle with daq_ready low");
        end

    a_ready_rst: assert property (@(posedge clk125) $rose(rst_n) |-> chan_ready)
        else begin
            fail_count++;
            $error("chan_ready low right after reset release");
        end

endmodule

bind wfd_daq_path wfd_daq_path_sva sva_i (
    .clk125      (clk125),
    .rst_n       (rst_n),
    .daq_valid   (daq_valid),
    .daq_header  (daq_header),
    .daq_trailer (daq_trailer),
    .daq_ready   (daq_ready),
    .chan_ready  (chan_ready)
);

//--- tests/wfd_daq_path_tb.sv
// wfd daq path testbench

`timescale 1ns/10ps

module wfd_daq_path_tb;
    import wfd_daq_pkg::*;

    logic       clk125;
    logic       rst_n;
    logic       chan_valid;
    chan_word_t chan_data;
    logic       chan_last;
    logic       chan_ready;
    logic       daq_valid;
    logic       daq_header;
    logic       daq_trailer;
    daq_word_t  daq_data;
    logic       daq_ready;

    daq_word_t  exp_data [$];    // expected beats, oldest first
    logic [1:0] exp_flags [$];   // {header, trailer} for each beat
    chan_word_t evt_words [$];   // channel words of the event being sent
    event_num_t model_evt;       // event number the model hands out next
    string      cur_test;
    int         errors;
    int         beats;           // beats seen on the daq bus
    logic       random_ready;    // daq_ready driven from $urandom
    logic       stall_seen;      // a channel word had to wait for chan_ready

    wfd_daq_path uut (
        .clk125      (clk125),
        .rst_n       (rst_n),
        .chan_valid  (chan_valid),
        .chan_data   (chan_data),
        .chan_last   (chan_last),
        .chan_ready  (chan_ready),
        .daq_valid   (daq_valid),
        .daq_header  (daq_header),
        .daq_trailer (daq_trailer),
        .daq_data    (daq_data),
        .daq_ready   (daq_ready)
    );

    always #5 clk125 = ~clk125;   // 125 MHz stand-in, 10 ns period

    task automatic check_word(input string test, input daq_word_t exp, input daq_word_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h, actual %h", test, exp, act);
        end
    endtask

    task automatic check_bits(input string test, input logic [1:0] exp, input logic [1:0] act);
        if (exp !== act) begin
            errors++;
            $display("error %s: expected flags %b, actual flags %b", test, exp, act);
        end
    endtask

    task automatic end_run();
        int total;
        total = errors + uut.sva_i.fail_count;   // compare errors plus assertion failures
        $display("errors: %0d compare, %0d assertion, %0d beats checked",
                 errors, uut.sva_i.fail_count, beats);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // one clock edge, with a fresh daq_ready level when it runs at random
    task automatic next_cycle();
        @(posedge clk125);
        if (random_ready) begin
            daq_ready <= (($urandom % 4) == 0);   // ready one cycle in four, buffer fills
        end
    endtask

    task automatic send_word(input chan_word_t data, input logic last);
        int waited;
        waited = 0;
        chan_valid <= 1'b1;
        chan_data  <= data;
        chan_last  <= last;
        next_cycle();
        while (!chan_ready && waited < 200) begin   // word held until the packer takes it
            stall_seen = 1'b1;
            waited++;
            next_cycle();
        end
        if (!chan_ready) begin
            errors++;
            $display("timeout: chan_ready stayed low for 200 cycles in test %s", cur_test);
            end_run();
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_data.size() != 0 && waited < 2000) begin
            next_cycle();
            waited++;
        end
        if (exp_data.size() != 0) begin
            errors++;
            $display("timeout: %0d expected beats never showed up in test %s",
                     exp_data.size(), cur_test);
            end_run();
        end
    endtask

    // expected beats of one event, straight from the word layout rules
    task automatic push_model();
        int          n;
        word_count_t cnt;
        n   = evt_words.size();
        cnt = word_count_t'(2 + (n + 1) / 2);   // header, packed words, trailer
        exp_data.push_back({HDR_MARK, model_evt, 32'h0000_0000});
        exp_flags.push_back(2'b10);
        for (int i = 0; i < n; i += 2) begin
            if (i + 1 < n) begin
                exp_data.push_back({evt_words[i], evt_words[i + 1]});   // first word on top
            end else begin
                exp_data.push_back({evt_words[i], 32'h0000_0000});      // odd tail padded
            end
            exp_flags.push_back(2'b00);
        end
        exp_data.push_back({TRL_MARK, model_evt, 12'h000, cnt});
        exp_flags.push_back(2'b01);
        model_evt = model_evt + 1'b1;
    endtask

    task automatic run_event(input int len);
        evt_words.delete();
        for (int i = 0; i < len; i++) begin
            evt_words.push_back($urandom);
        end
        push_model();   // model first, the header can come three cycles in
        for (int i = 0; i < len; i++) begin
            send_word(evt_words[i], (i == len - 1));
        end
        chan_valid <= 1'b0;
        chan_last  <= 1'b0;
    endtask

    task automatic test_reset();
        cur_test = "reset";
        check_bits(cur_test, 2'b01, {daq_valid, chan_ready});   // no beat, ready for words
    endtask

    task automatic test_even();
        cur_test = "even";
        run_event(4);   // event 0, two packed words, count 4
        wait_drained();
    endtask

    task automatic test_odd();
        cur_test = "odd";
        run_event(3);
        run_event(1);   // header, one padded word, trailer
        run_event(5);
        wait_drained();
    endtask

    task automatic test_numbering();
        cur_test = "numbering";
        run_event(2);   // back to back, no gap between events
        run_event(6);
        run_event(2);
        run_event(3);
        wait_drained();
    endtask

    task automatic test_backpressure();
        cur_test     = "backpressure";
        random_ready = 1'b1;
        stall_seen   = 1'b0;
        run_event(128);   // 64 packed words, four times the buffer depth
        run_event(7);
        wait_drained();
        random_ready = 1'b0;
        daq_ready   <= 1'b1;
        if (!stall_seen) begin
            errors++;
            $display("chan_ready never fell while the buffer was held by daq_ready");
        end
    endtask

    // collector, every beat against the head of the model queue
    always @(posedge clk125) begin : collect
        daq_word_t  want_data;
        logic [1:0] want_flags;
        if (rst_n && daq_valid) begin
            beats++;
            if (exp_data.size() == 0) begin
                errors++;
                $display("unexpected beat %h on the daq bus in test %s", daq_data, cur_test);
            end else begin
                want_data  = exp_data.pop_front();
                want_flags = exp_flags.pop_front();
                check_word(cur_test, want_data, daq_data);
                check_bits(cur_test, want_flags, {daq_header, daq_trailer});
            end
        end
    end

    initial begin
        void'($urandom(32'h1e5e8290));   // single seed for the run
        clk125       = 1'b0;
        rst_n        = 1'b0;
        chan_valid   = 1'b0;
        chan_data    = '0;
        chan_last    = 1'b0;
        daq_ready    = 1'b1;
        errors       = 0;
        beats        = 0;
        model_evt    = '0;
        random_ready = 1'b0;
        stall_seen   = 1'b0;
        cur_test     = "init";
        repeat (16) @(posedge clk125);
        rst_n <= 1'b1;
        next_cycle();
        test_reset();
        test_even();
        test_odd();
        test_numbering();
        test_backpressure();
        repeat (10) next_cycle();   // idle tail, stray beats would show here
        end_run();
    end

endmodule

//--- build.f
source/wfd_daq_pkg.sv
source/chan_word_packer.sv
source/event_fifo.sv
source/daq_event_builder.sv
source/wfd_daq_path.sv
tests/wfd_daq_path_sva.sv
tests/wfd_daq_path_tb.sv

//--- Bender.yml
package:
  name: wfd_daq_path

sources:
  - files:
      - source/wfd_daq_pkg.sv
      - source/chan_word_packer.sv
      - source/event_fifo.sv
      - source/daq_event_builder.sv
      - source/wfd_daq_path.sv
  - target: test
    files:
      - tests/wfd_daq_path_sva.sv
      - tests/wfd_daq_path_tb.sv
